// File: build.f
common/apu_reg_pkg.sv
common/wave_pkg.sv
common/ch3_ctrl_if.sv
ch3_regs/ch3_regs.sv
wave_ram/wave_ram.sv
ch3_core/ch3_core.sv
design/wave_channel_top.sv
dv/tb_wave_channel.sv

// File: Bender.yml
package:
  name: wave_channel

sources:
  # Packages and the interface come first.
  - common/apu_reg_pkg.sv
  - common/wave_pkg.sv
  - common/ch3_ctrl_if.sv
  # Design blocks.
  - ch3_regs/ch3_regs.sv
  - wave_ram/wave_ram.sv
  - ch3_core/ch3_core.sv
  - design/wave_channel_top.sv
  # Testbench.
  - target: test
    files:
      - dv/tb_wave_channel.sv

// File: dv/tb_wave_channel.sv
`timescale 1ns/100ps

module tb_wave_channel;

	typedef enum logic [2:0] {
		step_write,
		step_read,
		step_tick,
		step_wait,
		step_active,
		step_level,
		step_play
	} step_op_t;

	logic                   cery_2mhz;
	logic                   reset;
	apu_reg_pkg::reg_addr_t reg_addr;
	logic [7:0]             reg_wdata;
	logic                   reg_wr;
	logic [7:0]             reg_rdata;
	logic                   bufy_256hz;
	logic                   ch3_active;
	wave_pkg::sample_t      wave_dac_d;

	step_op_t   step_op   [160];
	logic [7:0] step_addr [160];
	logic [7:0] step_data [160];
	int         step_arg  [160];
	int         step_test [160];
	string      test_name [8];
	logic [7:0] exp_mem   [wave_pkg::wave_bytes];
	logic [7:0] play_mem  [wave_pkg::wave_bytes];   // Random bytes for the playback order.
	int         n_steps;
	int         n_tests;
	int         seed;
	int         errors;
	int         checks;
	int         cycles;
	int         cycle_limit;
	int         max_cost;
	logic       table_ready;

	wave_channel_top i_dut (
		.cery_2mhz  (cery_2mhz),
		.reset      (reset),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_wr     (reg_wr),
		.reg_rdata  (reg_rdata),
		.bufy_256hz (bufy_256hz),
		.ch3_active (ch3_active),
		.wave_dac_d (wave_dac_d)
	);

	initial begin
		cery_2mhz = 1'b0;
		forever #2 cery_2mhz = ~cery_2mhz;
	end

	// ------------------------------------------------------------------------
	// Step table
	// ------------------------------------------------------------------------

	task automatic add_step(input step_op_t op, input logic [7:0] addr, input logic [7:0] data,
	                        input int arg);
		int cost;
		cost = (op == step_wait) ? arg : (op == step_play) ? arg + 4 : 1;
		if (cost > max_cost)
			max_cost = cost;
		step_op[n_steps]   = op;
		step_addr[n_steps] = addr;
		step_data[n_steps] = data;
		step_arg[n_steps]  = arg;
		step_test[n_steps] = n_tests - 1;
		n_steps++;
	endtask

	task automatic begin_test(input string name);
		test_name[n_tests] = name;
		n_tests++;
	endtask

	task automatic add_write(input logic [7:0] addr, input logic [7:0] data);
		add_step(step_write, addr, data, 0);
	endtask

	task automatic add_read(input logic [7:0] addr, input logic [7:0] exp);
		add_step(step_read, addr, exp, 0);
	endtask

	task automatic add_wait(input int n);
		add_step(step_wait, 8'h00, 8'h00, n);
	endtask

	task automatic add_active_check(input logic exp);
		add_step(step_active, 8'h00, {7'b0, exp}, 0);
	endtask

	task automatic add_level_check(input logic [3:0] exp);
		add_step(step_level, 8'h00, {4'b0, exp}, 0);
	endtask

	task automatic fill_uniform(input logic [7:0] value);
		int i;
		for (i = 0; i < wave_pkg::wave_bytes; i++) begin
			exp_mem[i] = value;
			add_write(apu_reg_pkg::wave_base_addr + i, value);
		end
	endtask

	task automatic build_table();
		int i;
		begin_test("reset state");
		add_active_check(1'b0);
		add_level_check(4'd0);
		add_read(apu_reg_pkg::nr30_addr, 8'h00 | apu_reg_pkg::nr30_rmask);
		add_read(apu_reg_pkg::nr31_addr, 8'hFF);
		add_read(apu_reg_pkg::nr32_addr, 8'h00 | apu_reg_pkg::nr32_rmask);
		add_read(apu_reg_pkg::nr33_addr, 8'hFF);
		add_read(apu_reg_pkg::nr34_addr, 8'h00 | apu_reg_pkg::nr34_rmask);

		begin_test("wave RAM fill and unmapped reads");
		for (i = 0; i < wave_pkg::wave_bytes; i++)
			exp_mem[i] = $random(seed);
		// A zero first sample cannot be told apart from the silent output.
		if (exp_mem[0][7:4] == 4'h0)
			exp_mem[0][7:4] = 4'h9;
		play_mem = exp_mem;
		for (i = 0; i < wave_pkg::wave_bytes; i++)
			add_write(apu_reg_pkg::wave_base_addr + i, exp_mem[i]);
		for (i = 0; i < wave_pkg::wave_bytes; i++)
			add_read(apu_reg_pkg::wave_base_addr + i, exp_mem[i]);
		add_read(8'h10, 8'hFF);
		add_read(8'h1F, 8'hFF);
		add_read(8'h20, 8'hFF);
		add_read(8'h40, 8'hFF);

		begin_test("trigger and playback order");
		add_write(apu_reg_pkg::nr30_addr, 8'h80);
		add_write(apu_reg_pkg::nr32_addr, 8'h20);   // Full volume.
		add_write(apu_reg_pkg::nr33_addr, 8'hFF);
		add_write(apu_reg_pkg::nr34_addr, 8'h87);   // Trigger, freq 2047.
		add_active_check(1'b0);
		add_wait(1);
		add_active_check(1'b1);
		add_step(step_play, 8'h00, 8'h00, 64);

		begin_test("volume codes");
		add_write(apu_reg_pkg::nr30_addr, 8'h00);
		add_wait(2);
		add_active_check(1'b0);
		fill_uniform(8'hCC);
		add_write(apu_reg_pkg::nr30_addr, 8'h80);
		add_write(apu_reg_pkg::nr32_addr, 8'h20);
		add_write(apu_reg_pkg::nr34_addr, 8'h87);
		add_wait(3);
		add_level_check(4'd12);
		add_write(apu_reg_pkg::nr32_addr, 8'h40);
		add_wait(2);
		add_level_check(4'd6);
		add_write(apu_reg_pkg::nr32_addr, 8'h60);
		add_wait(2);
		add_level_check(4'd3);
		add_write(apu_reg_pkg::nr32_addr, 8'h00);
		add_wait(2);
		add_level_check(4'd0);

		begin_test("wave RAM access while active");
		add_active_check(1'b1);
		add_write(apu_reg_pkg::wave_base_addr + 3, 8'h55);   // Must be dropped.
		add_read(apu_reg_pkg::wave_base_addr + 3, exp_mem[3]);
		add_read(apu_reg_pkg::wave_base_addr + 10, exp_mem[10]);
		add_write(apu_reg_pkg::nr30_addr, 8'h00);
		add_wait(2);
		add_active_check(1'b0);
		add_read(apu_reg_pkg::wave_base_addr + 3, exp_mem[3]);

		begin_test("length counter and DAC off");
		add_write(apu_reg_pkg::nr30_addr, 8'h80);
		add_write(apu_reg_pkg::nr32_addr, 8'h20);
		add_write(apu_reg_pkg::nr31_addr, 8'hFC);   // Four length ticks.
		add_write(apu_reg_pkg::nr34_addr, 8'hC7);
		add_active_check(1'b0);
		add_wait(1);
		add_active_check(1'b1);
		for (i = 0; i < 3; i++)
			add_step(step_tick, 8'h00, 8'h00, 0);
		add_active_check(1'b1);
		add_step(step_tick, 8'h00, 8'h00, 0);
		add_active_check(1'b0);
		add_wait(1);
		add_level_check(4'd0);
		add_write(apu_reg_pkg::nr34_addr, 8'h87);
		add_wait(3);
		add_active_check(1'b1);
		add_level_check(4'd12);
		add_write(apu_reg_pkg::nr30_addr, 8'h00);
		add_wait(2);
		add_active_check(1'b0);
		add_level_check(4'd0);
	endtask

	// ------------------------------------------------------------------------
	// Step execution, each step starts 1 ns after a rising edge
	// ------------------------------------------------------------------------

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge cery_2mhz);
		#1;
	endtask

	task automatic check_playback(input int n);
		int         k;
		int         align;
		logic [7:0] b;
		logic [3:0] exp;
		align = 0;
		while (wave_dac_d !== play_mem[0][7:4] && align < 4) begin
			next_cycle();
			align++;
		end
		if (wave_dac_d !== play_mem[0][7:4]) begin
			errors++;
			$display("first sample did not appear within 4 cycles of the trigger");
		end else begin
			for (k = 0; k < n; k++) begin
				b   = play_mem[(k % 32) / 2];
				exp = (k % 2 == 0) ? b[7:4] : b[3:0];   // High nibble first.
				check_value("wave_dac_d", {4'b0, wave_dac_d}, {4'b0, exp});
				next_cycle();
			end
		end
	endtask

	task automatic run_step(input int i);
		case (step_op[i])
			step_write: begin
				reg_addr  = step_addr[i];
				reg_wdata = step_data[i];
				reg_wr    = 1'b1;
				next_cycle();
				reg_wr    = 1'b0;
			end
			step_read: begin
				reg_addr = step_addr[i];
				#1;
				check_value("reg_rdata", reg_rdata, step_data[i]);
				next_cycle();
			end
			step_tick: begin
				bufy_256hz = 1'b1;
				next_cycle();
				bufy_256hz = 1'b0;
			end
			step_wait: repeat (step_arg[i]) next_cycle();
			step_active: check_value("ch3_active", {7'b0, ch3_active}, step_data[i]);
			step_level: check_value("wave_dac_d", {4'b0, wave_dac_d}, step_data[i]);
			step_play: check_playback(step_arg[i]);
			default: ;
		endcase
	endtask

	initial begin
		cycles = 0;
		wait (table_ready);
		while (cycles <= cycle_limit) begin
			@(posedge cery_2mhz);
			cycles++;
		end
		$display("timeout after %0d cycles, the step table did not finish", cycles);
		$display("Something failed");
		$finish;
	end

	initial begin
		int i;
		int test_errors;
		reset       = 1'b1;
		reg_addr    = 8'h00;
		reg_wdata   = 8'h00;
		reg_wr      = 1'b0;
		bufy_256hz  = 1'b0;
		n_steps     = 0;
		n_tests     = 0;
		errors      = 0;
		checks      = 0;
		max_cost    = 1;
		seed        = 32'hbd004ac1;
		table_ready = 1'b0;
		build_table();
		cycle_limit = n_steps * max_cost + 200;   // Reset and margin.
		table_ready = 1'b1;

		repeat (16) @(posedge cery_2mhz);
		#1;
		reset = 1'b0;

		test_errors = 0;
		for (i = 0; i < n_steps; i++) begin
			run_step(i);
			if (i == n_steps - 1 || step_test[i + 1] != step_test[i]) begin
				$display("test %0d %s: %s (%0d errors)", step_test[i] + 1,
				         test_name[step_test[i]], (errors == test_errors) ? "pass" : "FAIL",
				         errors - test_errors);
				test_errors = errors;
			end
		end

		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: design/wave_channel_top.sv
`timescale 1ns/100ps

module wave_channel_top (
	input  logic                   cery_2mhz,
	input  logic                   reset,
	input  apu_reg_pkg::reg_addr_t reg_addr,
	input  logic [7:0]             reg_wdata,
	input  logic                   reg_wr,
	output logic [7:0]             reg_rdata,
	input  logic                   bufy_256hz,
	output logic                   ch3_active,
	output wave_pkg::sample_t      wave_dac_d
);

	logic [7:0]           ram_rdata;
	logic                 ram_we;
	wave_pkg::ram_addr_t  ram_waddr;
	wave_pkg::ram_addr_t  play_addr;
	wave_pkg::wave_byte_u play_byte;

	ch3_ctrl_if ctrl ();

	ch3_regs i_regs (
		.cery_2mhz  (cery_2mhz),
		.reset      (reset),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_wr     (reg_wr),
		.reg_rdata  (reg_rdata),
		.ch3_active (ch3_active),
		.ram_rdata  (ram_rdata),
		.ram_we     (ram_we),
		.ram_waddr  (ram_waddr),
		.ctrl       (ctrl.regs)
	);

	wave_ram i_ram (
		.cery_2mhz  (cery_2mhz),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.ram_we     (ram_we),
		.ram_waddr  (ram_waddr),
		.ram_rdata  (ram_rdata),
		.ch3_active (ch3_active),
		.play_addr  (play_addr),
		.play_byte  (play_byte)
	);

	ch3_core i_core (
		.cery_2mhz  (cery_2mhz),
		.reset      (reset),
		.ctrl       (ctrl.core),
		.bufy_256hz (bufy_256hz),
		.play_addr  (play_addr),
		.play_byte  (play_byte),
		.ch3_active (ch3_active),
		.wave_dac_d (wave_dac_d)
	);

endmodule

// File: ch3_core/ch3_core.sv
`timescale 1ns/100ps

module ch3_core (
	input  logic                 cery_2mhz,
	input  logic                 reset,
	ch3_ctrl_if.core             ctrl,
	input  logic                 bufy_256hz,
	output wave_pkg::ram_addr_t  play_addr,
	input  wave_pkg::wave_byte_u play_byte,
	output logic                 ch3_active,
	output wave_pkg::sample_t    wave_dac_d
);

	logic [apu_reg_pkg::freq_w-1:0] freq_timer;
	logic [apu_reg_pkg::freq_w:0]   timer_inc;
	logic                           timer_wrap;
	wave_pkg::pos_t                 pos;
	logic [apu_reg_pkg::len_w:0]    len_cnt;   // Holds 0 to 256.
	logic [apu_reg_pkg::len_w:0]    len_full;
	logic                           len_tick;
	logic                           len_expire;
	wave_pkg::sample_t              sample;

	// -------------------------------------------------------------------------
	// Frequency timer and sample position
	// -------------------------------------------------------------------------

	assign timer_inc  = {1'b0, freq_timer} + 1'b1;
	assign timer_wrap = timer_inc == wave_pkg::freq_limit;

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			freq_timer <= '0;
			pos        <= '0;
		end else if (ctrl.trigger) begin
			freq_timer <= ctrl.freq;
			pos        <= '0;
		end else if (ch3_active) begin
			if (timer_wrap) begin
				freq_timer <= ctrl.freq;   // Reload, period is 2048 minus freq.
				pos        <= pos + 1'b1;  // Wraps after 31.
			end else begin
				freq_timer <= timer_inc[apu_reg_pkg::freq_w-1:0];
			end
		end
	end

	assign play_addr = pos[4:1];
	assign sample    = pos[0] ? play_byte.nib.lo : play_byte.nib.hi;

	// -------------------------------------------------------------------------
	// Length counter
	// -------------------------------------------------------------------------

	assign len_full   = {1'b1, {apu_reg_pkg::len_w{1'b0}}};
	assign len_tick   = bufy_256hz && ctrl.length_en && ch3_active && len_cnt != '0;
	assign len_expire = len_tick && len_cnt == 9'd1;

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			len_cnt <= '0;
		end else if (ctrl.length_load) begin
			len_cnt <= len_full - {1'b0, ctrl.length_data};
		end else if (ctrl.trigger && len_cnt == '0) begin
			len_cnt <= len_full;   // Expired counter restarts at full length.
		end else if (len_tick) begin
			len_cnt <= len_cnt - 1'b1;
		end
	end

	// -------------------------------------------------------------------------
	// Active flag and output level
	// -------------------------------------------------------------------------

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			ch3_active <= 1'b0;
		end else if (!ctrl.dac_on) begin
			ch3_active <= 1'b0;   // DAC off also swallows a trigger.
		end else if (ctrl.trigger) begin
			ch3_active <= 1'b1;
		end else if (len_expire) begin
			ch3_active <= 1'b0;
		end
	end

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			wave_dac_d <= '0;
		end else if (!ch3_active) begin
			wave_dac_d <= '0;
		end else begin
			case (ctrl.vol_code)
				wave_pkg::vol_mute:    wave_dac_d <= '0;
				wave_pkg::vol_full:    wave_dac_d <= sample;
				wave_pkg::vol_half:    wave_dac_d <= sample >> 1;
				wave_pkg::vol_quarter: wave_dac_d <= sample >> 2;
			endcase
		end
	end

	// Output stays silent for the cycle after any inactive cycle.
	dac_quiet: assert property (@(posedge cery_2mhz) disable iff (reset)
		!ch3_active |=> wave_dac_d == '0);

endmodule

// File: wave_ram/wave_ram.sv
`timescale 1ns/100ps

module wave_ram (
	input  logic                   cery_2mhz,
	input  apu_reg_pkg::reg_addr_t reg_addr,
	input  logic [7:0]             reg_wdata,
	input  logic                   ram_we,
	input  wave_pkg::ram_addr_t    ram_waddr,
	output logic [7:0]             ram_rdata,
	input  logic                   ch3_active,
	input  wave_pkg::ram_addr_t    play_addr,
	output wave_pkg::wave_byte_u   play_byte
);

	wave_pkg::wave_byte_u mem [wave_pkg::wave_bytes];
	wave_pkg::ram_addr_t  cpu_raddr;

	// -------------------------------------------------------------------------
	// Storage
	// -------------------------------------------------------------------------

	always_ff @(posedge cery_2mhz) begin
		if (ram_we) begin
			mem[ram_waddr].raw <= reg_wdata;   // CPU sees the byte view.
		end
	end

	// -------------------------------------------------------------------------
	// Read ports
	// -------------------------------------------------------------------------

	// While playing, the CPU address is replaced by the play address.
	assign cpu_raddr = ch3_active ? play_addr : reg_addr[3:0];
	assign ram_rdata = mem[cpu_raddr].raw;

	assign play_byte = mem[play_addr];   // Core picks the nibble.

	// The register block gates the write enable with the core's active flag.
	no_write_active: assert property (@(posedge cery_2mhz)
		ram_we |-> !ch3_active);

endmodule

// File: ch3_regs/ch3_regs.sv
`timescale 1ns/100ps

module ch3_regs (
	input  logic                   cery_2mhz,
	input  logic                   reset,
	input  apu_reg_pkg::reg_addr_t reg_addr,
	input  logic [7:0]             reg_wdata,
	input  logic                   reg_wr,
	output logic [7:0]             reg_rdata,
	input  logic                   ch3_active,
	input  logic [7:0]             ram_rdata,
	output logic                   ram_we,
	output wave_pkg::ram_addr_t    ram_waddr,
	ch3_ctrl_if.regs               ctrl
);

	logic                           dac_on;
	logic [apu_reg_pkg::len_w-1:0]  length_data;
	wave_pkg::vol_code_t            vol_code;
	logic [apu_reg_pkg::freq_w-1:0] freq;
	logic                           length_en;
	logic                           wave_sel;

	assign wave_sel = reg_addr[7:4] == apu_reg_pkg::wave_base_addr[7:4];

	// -------------------------------------------------------------------------
	// Register storage
	// -------------------------------------------------------------------------

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			dac_on      <= apu_reg_pkg::nr3x_reset[apu_reg_pkg::dac_bit];
			length_data <= apu_reg_pkg::nr3x_reset;
			vol_code    <= apu_reg_pkg::nr3x_reset[apu_reg_pkg::vol_lsb +: 2];
			freq        <= {apu_reg_pkg::nr3x_reset[2:0], apu_reg_pkg::nr3x_reset};
			length_en   <= apu_reg_pkg::nr3x_reset[apu_reg_pkg::len_en_bit];
		end else if (reg_wr) begin
			case (reg_addr)
				apu_reg_pkg::nr30_addr: dac_on <= reg_wdata[apu_reg_pkg::dac_bit];
				apu_reg_pkg::nr31_addr: length_data <= reg_wdata;
				apu_reg_pkg::nr32_addr: vol_code <= reg_wdata[apu_reg_pkg::vol_lsb +: 2];
				apu_reg_pkg::nr33_addr: freq[7:0] <= reg_wdata;
				apu_reg_pkg::nr34_addr: begin
					freq[10:8] <= reg_wdata[2:0];
					length_en  <= reg_wdata[apu_reg_pkg::len_en_bit];
				end
				default: ;
			endcase
		end
	end

	// Pulses land one cycle after the write edge.
	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			ctrl.trigger     <= 1'b0;
			ctrl.length_load <= 1'b0;
		end else begin
			ctrl.trigger     <= reg_wr && reg_addr == apu_reg_pkg::nr34_addr &&
			                    reg_wdata[apu_reg_pkg::trig_bit];
			ctrl.length_load <= reg_wr && reg_addr == apu_reg_pkg::nr31_addr;
		end
	end

	assign ctrl.dac_on      = dac_on;
	assign ctrl.length_data = length_data;
	assign ctrl.vol_code    = vol_code;
	assign ctrl.freq        = freq;
	assign ctrl.length_en   = length_en;

	// -------------------------------------------------------------------------
	// Wave RAM write port and readback
	// -------------------------------------------------------------------------

	assign ram_we    = reg_wr && wave_sel && !ch3_active;   // CPU loses the RAM while playing.
	assign ram_waddr = reg_addr[3:0];

	always_comb begin
		case (reg_addr)
			apu_reg_pkg::nr30_addr: reg_rdata = {dac_on, 7'b0} | apu_reg_pkg::nr30_rmask;
			apu_reg_pkg::nr32_addr: reg_rdata = {1'b0, vol_code, 5'b0} | apu_reg_pkg::nr32_rmask;
			apu_reg_pkg::nr34_addr: reg_rdata = {1'b0, length_en, 6'b0} | apu_reg_pkg::nr34_rmask;
			default:                reg_rdata = wave_sel ? ram_rdata : apu_reg_pkg::unmapped_rdata;
		endcase
	end

	trigger_single: assert property (@(posedge cery_2mhz) disable iff (reset)
		ctrl.trigger |=> !ctrl.trigger);

endmodule

// File: common/ch3_ctrl_if.sv
`timescale 1ns/100ps

interface ch3_ctrl_if;

	logic                           dac_on;
	logic [apu_reg_pkg::len_w-1:0]  length_data;
	logic                           length_load;   // One cycle after an NR31 write.
	wave_pkg::vol_code_t            vol_code;
	logic [apu_reg_pkg::freq_w-1:0] freq;
	logic                           length_en;
	logic                           trigger;       // One cycle pulse.

	modport regs (
		output dac_on,
		output length_data,
		output length_load,
		output vol_code,
		output freq,
		output length_en,
		output trigger
	);

	modport core (
		input dac_on,
		input length_data,
		input length_load,
		input vol_code,
		input freq,
		input length_en,
		input trigger
	);

endinterface

// File: common/wave_pkg.sv
package wave_pkg;

	// -------------------------------------------------------------------------
	// Playback types
	// -------------------------------------------------------------------------

	typedef logic [3:0] sample_t;
	typedef logic [4:0] pos_t;        // 32 samples per loop.
	typedef logic [3:0] ram_addr_t;
	typedef logic [1:0] vol_code_t;

	// One RAM byte holds two samples, the first one in the high nibble.
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			sample_t hi;
			sample_t lo;
		} nib;
	} wave_byte_u;

	// NR32 output level codes.
	localparam vol_code_t vol_mute    = 2'd0;
	localparam vol_code_t vol_full    = 2'd1;
	localparam vol_code_t vol_half    = 2'd2;
	localparam vol_code_t vol_quarter = 2'd3;

	// -------------------------------------------------------------------------
	// Sizes and timing
	// -------------------------------------------------------------------------

	localparam int wave_bytes = 16;
	localparam int freq_limit = 2048;   // Timer wraps here, period is limit minus freq.

endpackage

// File: common/apu_reg_pkg.sv
package apu_reg_pkg;

	// -------------------------------------------------------------------------
	// Sound register address map
	// -------------------------------------------------------------------------

	typedef logic [7:0] reg_addr_t;   // Low byte of the 0xFFxx address.

	localparam reg_addr_t nr30_addr = 8'h1A;   // DAC enable.
	localparam reg_addr_t nr31_addr = 8'h1B;   // Length load.
	localparam reg_addr_t nr32_addr = 8'h1C;   // Output level.
	localparam reg_addr_t nr33_addr = 8'h1D;   // Frequency low byte.
	localparam reg_addr_t nr34_addr = 8'h1E;   // Frequency high, length enable, trigger.

	localparam reg_addr_t wave_base_addr = 8'h30;   // Wave RAM spans 0x30 to 0x3F.

	// -------------------------------------------------------------------------
	// Reset and readback
	// -------------------------------------------------------------------------

	localparam logic [7:0] nr3x_reset = 8'h00;   // All channel registers clear on reset.

	// Write-only bits come back as ones.
	localparam logic [7:0] nr30_rmask     = 8'h7F;
	localparam logic [7:0] nr32_rmask     = 8'h9F;
	localparam logic [7:0] nr34_rmask     = 8'hBF;
	localparam logic [7:0] unmapped_rdata = 8'hFF;   // Also NR31 and NR33.

	// -------------------------------------------------------------------------
	// Field positions and widths
	// -------------------------------------------------------------------------

	localparam int dac_bit    = 7;   // NR30.
	localparam int vol_lsb    = 5;   // NR32 bits 6..5.
	localparam int len_en_bit = 6;   // NR34.
	localparam int trig_bit   = 7;   // NR34.

	localparam int freq_w = 11;
	localparam int len_w  = 8;

endpackage
